// File: list.f
mmu_pkg.sv
mmu_tlb.sv
mmu_ptw.sv
mmu_fetch_xlate.sv
mmu_lsu_xlate.sv
mmu_top.sv
tb_mmu.sv

// File: tb_mmu.sv
// -------------------------------------------------
// Sv32 MMU testbench
// directed tests over bare mode, walks, megapages,
// permission faults, invalid PTEs and TLB flush
// -------------------------------------------------
module tb_mmu;
    timeunit 1ns;
    timeprecision 100ps;
    import mmu_pkg::*;

    localparam int unsigned TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] SEED = 32'h1b038293;
    // Sv32 PTE flag bits, low byte of the entry
    localparam logic [9:0] F_V = 10'h001, F_R = 10'h002, F_W = 10'h004, F_X = 10'h008;
    localparam logic [9:0] F_U = 10'h010, F_A = 10'h040, F_D = 10'h080;
    // page table layout: root, one level 0 table, leaf targets
    localparam logic [21:0] SATP_PPN = 22'h00100, L0_PPN = 22'h00101;
    localparam logic [21:0] CODE_PPN = 22'h80234, CLEAN_PPN = 22'h80300;
    localparam logic [21:0] USER_PPN = 22'h80400, MEGA_PPN = 22'h02c00;

    logic clk_i, rst_ni, enable_translation_i, en_ld_st_translation_i, sum_i, flush_tlb_i;
    priv_lvl_e priv_lvl_i, ld_st_priv_lvl_i;
    logic [21:0] satp_ppn_i;
    logic [8:0] asid_i;
    logic fetch_req_i, fetch_valid_o, lsu_req_i, lsu_is_store_i, lsu_valid_o;
    logic [31:0] fetch_vaddr_i, fetch_ex_tval_o, lsu_vaddr_i, lsu_ex_tval_o;
    logic [33:0] fetch_paddr_o, lsu_paddr_o, mem_addr_o;
    exc_cause_e fetch_ex_cause_o, lsu_ex_cause_o;
    logic mem_req_o, mem_rvalid_i;
    logic [31:0] mem_rdata_i;

    // sparse page table memory and read log
    logic [31:0] pt_mem [logic [33:0]];
    logic [33:0] rd_addr_q [$];
    int rd_cnt = 0, err_cnt = 0, test_cnt = 0, test_fail = 0, cycle_cnt = 0;
    // results of the last request
    logic [33:0] pa;
    logic [4:0]  cause;
    logic [31:0] tval;
    int lat;

    mmu_top dut (
        .clk_i, .rst_ni, .enable_translation_i, .en_ld_st_translation_i, .priv_lvl_i,
        .ld_st_priv_lvl_i, .sum_i, .satp_ppn_i, .asid_i, .flush_tlb_i,
        .fetch_req_i, .fetch_vaddr_i, .fetch_valid_o, .fetch_paddr_o, .fetch_ex_cause_o,
        .fetch_ex_tval_o, .lsu_req_i, .lsu_vaddr_i, .lsu_is_store_i, .lsu_valid_o,
        .lsu_paddr_o, .lsu_ex_cause_o, .lsu_ex_tval_o,
        .mem_req_o, .mem_addr_o, .mem_rvalid_i, .mem_rdata_i
    );

    initial clk_i = 1'b0;
    always #5 clk_i = ~clk_i;

    // run limit, about ten walks of under 20 cycles each, with a wide margin
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // every cycle with mem_req_o high counts as one read request
    always @(negedge clk_i) begin
        if (mem_req_o === 1'b1) begin
            rd_cnt++;
        end
    end

    function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [9:0] flags);
        return {ppn, flags};
    endfunction

    // missing entries read as zero, which is an invalid PTE
    function automatic logic [31:0] read_pte(input logic [33:0] addr);
        if (pt_mem.exists(addr)) return pt_mem[addr];
        return 32'h0;
    endfunction

    // ---------------------------------------------
    // memory model, one read in flight, 1 to 4 cycles
    // ---------------------------------------------
    initial begin
        int unsigned wait_cycles;
        logic [33:0] addr;
        void'($urandom(SEED));
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        forever begin
            @(negedge clk_i);
            mem_rvalid_i = 1'b0;
            if (mem_req_o) begin
                addr = mem_addr_o;
                rd_addr_q.push_back(addr);
                wait_cycles = $urandom_range(4, 1);
                repeat (wait_cycles) @(negedge clk_i);
                mem_rvalid_i = 1'b1;
                mem_rdata_i  = read_pte(addr);
            end
        end
    end

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            test_fail++;
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // drive a fetch at the falling edge, hold it until valid
    // lat counts rising edges after the first one
    task automatic run_fetch(input logic [31:0] va);
        lat = 0;
        @(negedge clk_i);
        fetch_req_i   = 1'b1;
        fetch_vaddr_i = va;
        @(posedge clk_i);
        while (!fetch_valid_o) begin
            lat++;
            @(posedge clk_i);
        end
        pa    = fetch_paddr_o;
        cause = fetch_ex_cause_o;
        tval  = fetch_ex_tval_o;
        @(negedge clk_i);
        fetch_req_i = 1'b0;
    endtask

    task automatic run_lsu(input logic [31:0] va, input logic is_store);
        lat = 0;
        @(negedge clk_i);
        lsu_req_i      = 1'b1;
        lsu_vaddr_i    = va;
        lsu_is_store_i = is_store;
        @(posedge clk_i);
        while (!lsu_valid_o) begin
            lat++;
            @(posedge clk_i);
        end
        pa    = lsu_paddr_o;
        cause = lsu_ex_cause_o;
        tval  = lsu_ex_tval_o;
        @(negedge clk_i);
        lsu_req_i = 1'b0;
    endtask

    // ---------------------------------------------
    // directed tests
    // ---------------------------------------------
    task automatic bare_mode();
        int e0 = err_cnt;
        int r0 = rd_cnt;
        run_fetch(32'hdead_beef);
        compare_value("fetch_paddr_o", pa, {2'b00, 32'hdead_beef});
        compare_value("fetch latency", lat, 0);
        compare_value("fetch_ex_cause_o", cause, EXC_NONE);
        run_lsu(32'h8000_1234, 1'b0);
        compare_value("lsu_paddr_o", pa, {2'b00, 32'h8000_1234});
        compare_value("lsu latency", lat, 1);
        compare_value("mem reads", rd_cnt - r0, 0);
        report_test("bare_mode", e0);
    endtask

    // 4 KiB code page at 0x00401000, used again after a flush
    task automatic fetch_4k_page(input string name);
        int e0 = err_cnt;
        int r0 = rd_cnt;
        @(negedge clk_i);
        enable_translation_i = 1'b1;
        priv_lvl_i = PRIV_S;
        rd_addr_q.delete();
        run_fetch(32'h0040_1234);
        compare_value("mem reads", rd_cnt - r0, 2);
        if (rd_addr_q.size() == 2) begin
            compare_value("mem_addr_o lvl1", rd_addr_q[0], {SATP_PPN, 10'h001, 2'b00});
            compare_value("mem_addr_o lvl0", rd_addr_q[1], {L0_PPN, 10'h001, 2'b00});
        end
        compare_value("fetch_paddr_o", pa, {CODE_PPN, 12'h234});
        compare_value("fetch_ex_cause_o", cause, EXC_NONE);
        // same page again hits the ITLB
        r0 = rd_cnt;
        run_fetch(32'h0040_1ffc);
        compare_value("mem reads", rd_cnt - r0, 0);
        compare_value("fetch latency", lat, 0);
        compare_value("fetch_paddr_o", pa, {CODE_PPN, 12'hffc});
        report_test(name, e0);
    endtask

    task automatic megapage_load();
        int e0 = err_cnt;
        int r0 = rd_cnt;
        @(negedge clk_i);
        en_ld_st_translation_i = 1'b1;
        ld_st_priv_lvl_i = PRIV_S;
        run_lsu(32'h0c12_3456, 1'b0);
        compare_value("mem reads", rd_cnt - r0, 1);
        compare_value("lsu_paddr_o", pa, {MEGA_PPN[21:10], 22'h12_3456});
        compare_value("lsu_ex_cause_o", cause, EXC_NONE);
        report_test("megapage_load", e0);
    endtask

    task automatic permission_faults();
        int e0 = err_cnt;
        @(negedge clk_i);
        priv_lvl_i = PRIV_U;
        run_fetch(32'h0040_1000);
        compare_value("fetch_ex_cause_o", cause, EXC_INSTR_PAGE_FAULT);
        compare_value("fetch_ex_tval_o", tval, 32'h0040_1000);
        priv_lvl_i = PRIV_S;
        // W set but D clear
        run_lsu(32'h0040_2010, 1'b1);
        compare_value("lsu_ex_cause_o", cause, EXC_STORE_PAGE_FAULT);
        compare_value("lsu_ex_tval_o", tval, 32'h0040_2010);
        // user page from S mode
        run_lsu(32'h0040_3020, 1'b0);
        compare_value("lsu_ex_cause_o", cause, EXC_LOAD_PAGE_FAULT);
        compare_value("lsu_ex_tval_o", tval, 32'h0040_3020);
        sum_i = 1'b1;
        // the page is in the DTLB now, so one cycle
        run_lsu(32'h0040_3020, 1'b0);
        compare_value("lsu_ex_cause_o", cause, EXC_NONE);
        compare_value("lsu_paddr_o", pa, {USER_PPN, 12'h020});
        compare_value("lsu latency", lat, 1);
        sum_i = 1'b0;
        report_test("permission_faults", e0);
    endtask

    task automatic invalid_pte();
        int e0 = err_cnt;
        int r0 = rd_cnt;
        run_lsu(32'h0040_4008, 1'b0);
        compare_value("mem reads", rd_cnt - r0, 2);
        compare_value("lsu_ex_cause_o", cause, EXC_LOAD_PAGE_FAULT);
        compare_value("lsu_ex_tval_o", tval, 32'h0040_4008);
        report_test("invalid_pte", e0);
    endtask

    initial begin
        rst_ni = 1'b0;
        enable_translation_i = 1'b0;
        en_ld_st_translation_i = 1'b0;
        priv_lvl_i = PRIV_S;
        ld_st_priv_lvl_i = PRIV_S;
        sum_i = 1'b0;
        satp_ppn_i = SATP_PPN;
        asid_i = 9'h005;
        flush_tlb_i = 1'b0;
        fetch_req_i = 1'b0;
        fetch_vaddr_i = '0;
        lsu_req_i = 1'b0;
        lsu_vaddr_i = '0;
        lsu_is_store_i = 1'b0;
        pt_mem[{SATP_PPN, 10'h001, 2'b00}] = make_pte(L0_PPN, F_V);
        pt_mem[{SATP_PPN, 10'h030, 2'b00}] = make_pte(MEGA_PPN, F_V | F_R | F_W | F_A | F_D);
        pt_mem[{L0_PPN, 10'h001, 2'b00}] = make_pte(CODE_PPN, F_V | F_R | F_X | F_A);
        pt_mem[{L0_PPN, 10'h002, 2'b00}] = make_pte(CLEAN_PPN, F_V | F_R | F_W | F_A);
        pt_mem[{L0_PPN, 10'h003, 2'b00}] = make_pte(USER_PPN, F_V | F_R | F_W | F_U | F_A | F_D);
        // V clear
        pt_mem[{L0_PPN, 10'h004, 2'b00}] = make_pte(22'h80500, F_R | F_W | F_A | F_D);
        repeat (10) @(negedge clk_i);
        rst_ni = 1'b1;
        bare_mode();
        fetch_4k_page("fetch_4k_walk");
        megapage_load();
        permission_faults();
        invalid_pte();
        @(negedge clk_i);
        flush_tlb_i = 1'b1;
        @(negedge clk_i);
        flush_tlb_i = 1'b0;
        fetch_4k_page("flush_refill");
        $display("tests %0d, failed %0d, errors %0d, memory reads %0d",
                 test_cnt, test_fail, err_cnt, rd_cnt);
        if (err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: mmu_top.sv
// -------------------------------------------------
// Sv32 MMU top level
// ITLB, DTLB, shared walker, fetch and lsu paths
// -------------------------------------------------
module mmu_top #(
    parameter int unsigned ITLB_ENTRIES = 4,
    parameter int unsigned DTLB_ENTRIES = 4,
    parameter int unsigned ASID_W       = mmu_pkg::ASID_W
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        enable_translation_i,
    input  logic                        en_ld_st_translation_i,
    input  mmu_pkg::priv_lvl_e          priv_lvl_i,
    input  mmu_pkg::priv_lvl_e          ld_st_priv_lvl_i,
    input  logic                        sum_i,
    input  logic [mmu_pkg::PPN_W-1:0]   satp_ppn_i,
    input  logic [ASID_W-1:0]           asid_i,
    input  logic                        flush_tlb_i,
    // fetch
    input  logic                        fetch_req_i,
    input  logic [mmu_pkg::VLEN-1:0]    fetch_vaddr_i,
    output logic                        fetch_valid_o,
    output logic [mmu_pkg::PLEN-1:0]    fetch_paddr_o,
    output mmu_pkg::exc_cause_e         fetch_ex_cause_o,
    output logic [mmu_pkg::VLEN-1:0]    fetch_ex_tval_o,
    // load/store
    input  logic                        lsu_req_i,
    input  logic [mmu_pkg::VLEN-1:0]    lsu_vaddr_i,
    input  logic                        lsu_is_store_i,
    output logic                        lsu_valid_o,
    output logic [mmu_pkg::PLEN-1:0]    lsu_paddr_o,
    output mmu_pkg::exc_cause_e         lsu_ex_cause_o,
    output logic [mmu_pkg::VLEN-1:0]    lsu_ex_tval_o,
    // page table memory
    output logic                        mem_req_o,
    output logic [mmu_pkg::PLEN-1:0]    mem_addr_o,
    input  logic                        mem_rvalid_i,
    input  logic [mmu_pkg::PTE_W-1:0]   mem_rdata_i
);
    import mmu_pkg::*;

    logic                      itlb_hit, itlb_mega, dtlb_hit, dtlb_mega;
    logic [PTE_W-1:0]          itlb_pte, dtlb_pte, update_pte;
    logic                      itlb_update, dtlb_update, update_mega;
    logic [VLEN-PAGE_OFFSET_W-1:0] update_vpn;
    logic [ASID_W-1:0]         update_asid;
    logic                      ptw_active, walking_instr, ptw_fault;
    logic [VLEN-1:0]           fault_vaddr;

    mmu_tlb #(.ENTRIES(ITLB_ENTRIES), .ASID_W(ASID_W)) i_itlb (
        .clk_i, .rst_ni, .flush_i(flush_tlb_i),
        .update_i(itlb_update), .update_vpn_i(update_vpn), .update_asid_i(update_asid),
        .update_pte_i(update_pte), .update_mega_i(update_mega),
        .lu_access_i(fetch_req_i), .lu_vaddr_i(fetch_vaddr_i), .lu_asid_i(asid_i),
        .lu_hit_o(itlb_hit), .lu_pte_o(itlb_pte), .lu_mega_o(itlb_mega)
    );

    mmu_tlb #(.ENTRIES(DTLB_ENTRIES), .ASID_W(ASID_W)) i_dtlb (
        .clk_i, .rst_ni, .flush_i(flush_tlb_i),
        .update_i(dtlb_update), .update_vpn_i(update_vpn), .update_asid_i(update_asid),
        .update_pte_i(update_pte), .update_mega_i(update_mega),
        .lu_access_i(lsu_req_i), .lu_vaddr_i(lsu_vaddr_i), .lu_asid_i(asid_i),
        .lu_hit_o(dtlb_hit), .lu_pte_o(dtlb_pte), .lu_mega_o(dtlb_mega)
    );

    mmu_ptw #(.ASID_W(ASID_W)) i_ptw (
        .clk_i, .rst_ni, .enable_translation_i, .en_ld_st_translation_i,
        .satp_ppn_i, .asid_i,
        .itlb_access_i(fetch_req_i), .itlb_hit_i(itlb_hit), .itlb_vaddr_i(fetch_vaddr_i),
        .dtlb_access_i(lsu_req_i), .dtlb_hit_i(dtlb_hit), .dtlb_vaddr_i(lsu_vaddr_i),
        .mem_req_o, .mem_addr_o, .mem_rvalid_i, .mem_rdata_i,
        .itlb_update_o(itlb_update), .dtlb_update_o(dtlb_update),
        .update_vpn_o(update_vpn), .update_asid_o(update_asid),
        .update_pte_o(update_pte), .update_mega_o(update_mega),
        .ptw_active_o(ptw_active), .walking_instr_o(walking_instr),
        .ptw_fault_o(ptw_fault), .fault_vaddr_o(fault_vaddr)
    );

    mmu_fetch_xlate i_fetch (
        .enable_translation_i, .priv_lvl_i, .fetch_req_i, .fetch_vaddr_i,
        .itlb_hit_i(itlb_hit), .itlb_pte_i(itlb_pte), .itlb_mega_i(itlb_mega),
        .ptw_active_i(ptw_active), .walking_instr_i(walking_instr),
        .ptw_fault_i(ptw_fault), .fault_vaddr_i(fault_vaddr),
        .fetch_valid_o, .fetch_paddr_o, .fetch_ex_cause_o, .fetch_ex_tval_o
    );

    mmu_lsu_xlate i_lsu (
        .clk_i, .rst_ni, .en_ld_st_translation_i, .ld_st_priv_lvl_i, .sum_i,
        .lsu_req_i, .lsu_vaddr_i, .lsu_is_store_i,
        .dtlb_hit_i(dtlb_hit), .dtlb_pte_i(dtlb_pte), .dtlb_mega_i(dtlb_mega),
        .ptw_active_i(ptw_active), .walking_instr_i(walking_instr),
        .ptw_fault_i(ptw_fault), .fault_vaddr_i(fault_vaddr),
        .lsu_valid_o, .lsu_paddr_o, .lsu_ex_cause_o, .lsu_ex_tval_o
    );

endmodule

// File: mmu_lsu_xlate.sv
// -------------------------------------------------
// load/store translation
// DTLB result registered, checked one cycle later
// -------------------------------------------------
module mmu_lsu_xlate (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        en_ld_st_translation_i,
    input  mmu_pkg::priv_lvl_e          ld_st_priv_lvl_i,
    input  logic                        sum_i,
    input  logic                        lsu_req_i,
    input  logic [mmu_pkg::VLEN-1:0]    lsu_vaddr_i,
    input  logic                        lsu_is_store_i,
    input  logic                        dtlb_hit_i,
    input  logic [mmu_pkg::PTE_W-1:0]   dtlb_pte_i,
    input  logic                        dtlb_mega_i,
    input  logic                        ptw_active_i,
    input  logic                        walking_instr_i,
    input  logic                        ptw_fault_i,
    input  logic [mmu_pkg::VLEN-1:0]    fault_vaddr_i,
    output logic                        lsu_valid_o,
    output logic [mmu_pkg::PLEN-1:0]    lsu_paddr_o,
    output mmu_pkg::exc_cause_e         lsu_ex_cause_o,
    output logic [mmu_pkg::VLEN-1:0]    lsu_ex_tval_o
);
    import mmu_pkg::*;

    logic             lsu_req_q, dtlb_hit_q, is_store_q, mega_q;
    logic [VLEN-1:0]  vaddr_q;
    logic [PTE_W-1:0] pte_q;
    logic             priv_err, perm_err;
    exc_cause_e       fault_cause;

    // S mode reaches user pages only with SUM
    assign priv_err = ((ld_st_priv_lvl_i == PRIV_S) && !sum_i && pte_q[PTE_U_BIT])
                   || ((ld_st_priv_lvl_i == PRIV_U) && !pte_q[PTE_U_BIT]);
    // a store also needs the dirty bit already set
    assign perm_err = is_store_q ? (!pte_q[PTE_W_BIT] || !pte_q[PTE_D_BIT])
                                 : !pte_q[PTE_R_BIT];
    assign fault_cause = is_store_q ? EXC_STORE_PAGE_FAULT : EXC_LOAD_PAGE_FAULT;

    always_comb begin
        lsu_valid_o    = lsu_req_q;
        lsu_paddr_o    = {{(PLEN - VLEN){1'b0}}, vaddr_q};
        lsu_ex_cause_o = EXC_NONE;
        lsu_ex_tval_o  = '0;
        if (en_ld_st_translation_i) begin
            lsu_valid_o = 1'b0;
            lsu_paddr_o = {pte_q[PTE_PPN_LSB +: PPN_W], vaddr_q[PAGE_OFFSET_W-1:0]};
            if (mega_q) begin
                lsu_paddr_o[PAGE_OFFSET_W +: VPN_W] = vaddr_q[PAGE_OFFSET_W +: VPN_W];
            end
            if (lsu_req_q && dtlb_hit_q) begin
                lsu_valid_o = 1'b1;
                if (perm_err || priv_err) begin
                    lsu_ex_cause_o = fault_cause;
                    lsu_ex_tval_o  = vaddr_q;
                end
            end else if (lsu_req_q && ptw_active_i && !walking_instr_i && ptw_fault_i) begin
                // data walk failed
                lsu_valid_o    = 1'b1;
                lsu_ex_cause_o = fault_cause;
                lsu_ex_tval_o  = fault_vaddr_i;
            end
        end
    end

    // request stage
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lsu_req_q  <= 1'b0;
            dtlb_hit_q <= 1'b0;
        end else begin
            lsu_req_q  <= lsu_req_i;
            dtlb_hit_q <= dtlb_hit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q    <= lsu_vaddr_i;
        is_store_q <= lsu_is_store_i;
        pte_q      <= dtlb_pte_i;
        mega_q     <= dtlb_mega_i;
    end

endmodule

// File: mmu_fetch_xlate.sv
// -------------------------------------------------
// fetch translation
// combinational ITLB result, X and U checks
// -------------------------------------------------
module mmu_fetch_xlate (
    input  logic                        enable_translation_i,
    input  mmu_pkg::priv_lvl_e          priv_lvl_i,
    input  logic                        fetch_req_i,
    input  logic [mmu_pkg::VLEN-1:0]    fetch_vaddr_i,
    input  logic                        itlb_hit_i,
    input  logic [mmu_pkg::PTE_W-1:0]   itlb_pte_i,
    input  logic                        itlb_mega_i,
    input  logic                        ptw_active_i,
    input  logic                        walking_instr_i,
    input  logic                        ptw_fault_i,
    input  logic [mmu_pkg::VLEN-1:0]    fault_vaddr_i,
    output logic                        fetch_valid_o,
    output logic [mmu_pkg::PLEN-1:0]    fetch_paddr_o,
    output mmu_pkg::exc_cause_e         fetch_ex_cause_o,
    output logic [mmu_pkg::VLEN-1:0]    fetch_ex_tval_o
);
    import mmu_pkg::*;

    logic priv_err;

    // U mode needs a user page, S mode must not execute one
    assign priv_err = ((priv_lvl_i == PRIV_U) && !itlb_pte_i[PTE_U_BIT])
                   || ((priv_lvl_i == PRIV_S) && itlb_pte_i[PTE_U_BIT]);

    always_comb begin
        // bare mode passes the address through
        fetch_valid_o    = fetch_req_i;
        fetch_paddr_o    = {{(PLEN - VLEN){1'b0}}, fetch_vaddr_i};
        fetch_ex_cause_o = EXC_NONE;
        fetch_ex_tval_o  = '0;
        if (enable_translation_i) begin
            fetch_valid_o = 1'b0;
            fetch_paddr_o = {itlb_pte_i[PTE_PPN_LSB +: PPN_W], fetch_vaddr_i[PAGE_OFFSET_W-1:0]};
            // megapage keeps vpn0 from the vaddr
            if (itlb_mega_i) begin
                fetch_paddr_o[PAGE_OFFSET_W +: VPN_W] = fetch_vaddr_i[PAGE_OFFSET_W +: VPN_W];
            end
            if (itlb_hit_i) begin
                fetch_valid_o = fetch_req_i;
                if (!itlb_pte_i[PTE_X_BIT] || priv_err) begin
                    fetch_ex_cause_o = EXC_INSTR_PAGE_FAULT;
                    fetch_ex_tval_o  = fetch_vaddr_i;
                end
            end else if (ptw_active_i && walking_instr_i && ptw_fault_i) begin
                // walk for this fetch failed, complete it with a fault
                fetch_valid_o    = fetch_req_i;
                fetch_ex_cause_o = EXC_INSTR_PAGE_FAULT;
                fetch_ex_tval_o  = fault_vaddr_i;
            end
        end
    end

endmodule

// File: mmu_ptw.sv
// -------------------------------------------------
// Sv32 page table walker
// two level walk from satp, one read in flight,
// refills the ITLB or DTLB that missed
// -------------------------------------------------
module mmu_ptw #(
    parameter int unsigned ASID_W = mmu_pkg::ASID_W
) (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  logic                                           enable_translation_i,
    input  logic                                           en_ld_st_translation_i,
    input  logic [mmu_pkg::PPN_W-1:0]                      satp_ppn_i,
    input  logic [ASID_W-1:0]                              asid_i,
    input  logic                                           itlb_access_i,
    input  logic                                           itlb_hit_i,
    input  logic [mmu_pkg::VLEN-1:0]                       itlb_vaddr_i,
    input  logic                                           dtlb_access_i,
    input  logic                                           dtlb_hit_i,
    input  logic [mmu_pkg::VLEN-1:0]                       dtlb_vaddr_i,
    output logic                                           mem_req_o,
    output logic [mmu_pkg::PLEN-1:0]                       mem_addr_o,
    input  logic                                           mem_rvalid_i,
    input  logic [mmu_pkg::PTE_W-1:0]                      mem_rdata_i,
    output logic                                           itlb_update_o,
    output logic                                           dtlb_update_o,
    output logic [mmu_pkg::VLEN-mmu_pkg::PAGE_OFFSET_W-1:0] update_vpn_o,
    output logic [ASID_W-1:0]                              update_asid_o,
    output logic [mmu_pkg::PTE_W-1:0]                      update_pte_o,
    output logic                                           update_mega_o,
    output logic                                           ptw_active_o,
    output logic                                           walking_instr_o,
    output logic                                           ptw_fault_o,
    output logic [mmu_pkg::VLEN-1:0]                       fault_vaddr_o
);
    import mmu_pkg::*;

    ptw_state_e       state_q, state_d;
    logic             instr_q;
    logic [VLEN-1:0]  vaddr_q;
    // ppn of the level 0 table
    logic [PPN_W-1:0] ppn_q;
    logic             start_instr, start_data;
    logic             is_lvl1, pte_leaf, pte_fault, leaf_valid;

    // miss requests, fetch side has priority
    assign start_instr = enable_translation_i && itlb_access_i && !itlb_hit_i;
    assign start_data  = en_ld_st_translation_i && dtlb_access_i && !dtlb_hit_i;

    // ---------------------------------------------
    // PTE decode
    // ---------------------------------------------
    assign is_lvl1  = (state_q == LVL1_WAIT);
    assign pte_leaf = mem_rdata_i[PTE_R_BIT] || mem_rdata_i[PTE_X_BIT];
    always_comb begin
        pte_fault = !mem_rdata_i[PTE_V_BIT]
            || (mem_rdata_i[PTE_W_BIT] && !mem_rdata_i[PTE_R_BIT])
            || (pte_leaf && !mem_rdata_i[PTE_A_BIT])
            // superpage must be aligned to 4 MiB
            || (is_lvl1 && pte_leaf && (|mem_rdata_i[PTE_PPN_LSB +: VPN_W]))
            // no third level in Sv32
            || (!is_lvl1 && !pte_leaf);
    end

    // ---------------------------------------------
    // walk FSM
    // ---------------------------------------------
    always_comb begin
        state_d     = state_q;
        mem_req_o   = 1'b0;
        mem_addr_o  = {satp_ppn_i, vaddr_q[VLEN-1 -: VPN_W], 2'b00};
        ptw_fault_o = 1'b0;
        leaf_valid  = 1'b0;
        unique case (state_q)
            IDLE: begin
                if (start_instr || start_data) begin
                    state_d = LVL1_REQ;
                end
            end
            LVL1_REQ: begin
                mem_req_o = 1'b1;
                state_d   = LVL1_WAIT;
            end
            LVL0_REQ: begin
                mem_req_o  = 1'b1;
                mem_addr_o = {ppn_q, vaddr_q[PAGE_OFFSET_W +: VPN_W], 2'b00};
                state_d    = LVL0_WAIT;
            end
            LVL1_WAIT, LVL0_WAIT: begin
                if (mem_rvalid_i) begin
                    if (pte_fault) begin
                        ptw_fault_o = 1'b1;
                        state_d     = IDLE;
                    end else if (pte_leaf) begin
                        leaf_valid = 1'b1;
                        state_d    = IDLE;
                    end else begin
                        // pointer to the next level
                        state_d = LVL0_REQ;
                    end
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            instr_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE && (start_instr || start_data)) begin
                instr_q <= start_instr;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) begin
            vaddr_q <= start_instr ? itlb_vaddr_i : dtlb_vaddr_i;
        end
        if (is_lvl1 && mem_rvalid_i) begin
            ppn_q <= mem_rdata_i[PTE_PPN_LSB +: PPN_W];
        end
    end

    // refill and status
    assign itlb_update_o   = leaf_valid && instr_q;
    assign dtlb_update_o   = leaf_valid && !instr_q;
    assign update_vpn_o    = vaddr_q[VLEN-1:PAGE_OFFSET_W];
    assign update_asid_o   = asid_i;
    assign update_pte_o    = mem_rdata_i;
    assign update_mega_o   = is_lvl1;
    assign ptw_active_o    = (state_q != IDLE);
    assign walking_instr_o = instr_q;
    assign fault_vaddr_o   = vaddr_q;

endmodule

// File: mmu_tlb.sv
// -------------------------------------------------
// fully associative Sv32 TLB
// same cycle lookup, round-robin refill, full flush
// -------------------------------------------------
module mmu_tlb #(
    parameter int unsigned ENTRIES = 4,
    parameter int unsigned ASID_W  = mmu_pkg::ASID_W
) (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  logic                                           flush_i,
    input  logic                                           update_i,
    input  logic [mmu_pkg::VLEN-mmu_pkg::PAGE_OFFSET_W-1:0] update_vpn_i,
    input  logic [ASID_W-1:0]                              update_asid_i,
    input  logic [mmu_pkg::PTE_W-1:0]                      update_pte_i,
    input  logic                                           update_mega_i,
    input  logic                                           lu_access_i,
    input  logic [mmu_pkg::VLEN-1:0]                       lu_vaddr_i,
    input  logic [ASID_W-1:0]                              lu_asid_i,
    output logic                                           lu_hit_o,
    output logic [mmu_pkg::PTE_W-1:0]                      lu_pte_o,
    output logic                                           lu_mega_o
);
    import mmu_pkg::*;

    localparam int unsigned IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

    // per entry tags and payload
    logic [ENTRIES-1:0] valid_q;
    logic [VPN_W-1:0]   vpn1_q [ENTRIES];
    logic [VPN_W-1:0]   vpn0_q [ENTRIES];
    logic [ASID_W-1:0]  asid_q [ENTRIES];
    logic [PTE_W-1:0]   pte_q  [ENTRIES];
    logic [ENTRIES-1:0] mega_q;
    // next slot to refill
    logic [IDX_W-1:0]   rr_ptr_q;
    logic [ENTRIES-1:0] match;

    // ---------------------------------------------
    // lookup
    // ---------------------------------------------
    always_comb begin
        lu_pte_o  = '0;
        lu_mega_o = 1'b0;
        for (int i = 0; i < ENTRIES; i++) begin
            // vpn0 is a don't care for a 4 MiB page, asid for a global one
            match[i] = valid_q[i]
                && (vpn1_q[i] == lu_vaddr_i[VLEN-1 -: VPN_W])
                && (mega_q[i] || (vpn0_q[i] == lu_vaddr_i[PAGE_OFFSET_W +: VPN_W]))
                && (pte_q[i][PTE_G_BIT] || (asid_q[i] == lu_asid_i));
            if (match[i]) begin
                lu_pte_o  = pte_q[i];
                lu_mega_o = mega_q[i];
            end
        end
    end

    assign lu_hit_o = lu_access_i && (|match);

    // ---------------------------------------------
    // refill and flush
    // ---------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            rr_ptr_q <= '0;
        end else if (flush_i) begin
            // flush drops every entry, asid is not looked at
            valid_q <= '0;
        end else if (update_i) begin
            valid_q[rr_ptr_q] <= 1'b1;
            rr_ptr_q <= (rr_ptr_q == IDX_W'(ENTRIES - 1)) ? '0 : rr_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (update_i) begin
            vpn1_q[rr_ptr_q] <= update_vpn_i[VPN_W +: VPN_W];
            vpn0_q[rr_ptr_q] <= update_vpn_i[0 +: VPN_W];
            asid_q[rr_ptr_q] <= update_asid_i;
            pte_q[rr_ptr_q]  <= update_pte_i;
            mega_q[rr_ptr_q] <= update_mega_i;
        end
    end

endmodule

// File: mmu_pkg.sv
// -------------------------------------------------
// mmu package
// Sv32 widths, PTE field positions, privilege levels,
// exception causes and page table walker states
// -------------------------------------------------
package mmu_pkg;

    // address and page geometry
    localparam int unsigned VLEN          = 32;
    localparam int unsigned PLEN          = 34;
    localparam int unsigned PPN_W         = 22;
    localparam int unsigned VPN_W         = 10;
    localparam int unsigned PAGE_OFFSET_W = 12;
    localparam int unsigned ASID_W        = 9;
    localparam int unsigned PTE_W         = 32;

    // PTE flag bit positions
    localparam int unsigned PTE_V_BIT   = 0;
    localparam int unsigned PTE_R_BIT   = 1;
    localparam int unsigned PTE_W_BIT   = 2;
    localparam int unsigned PTE_X_BIT   = 3;
    localparam int unsigned PTE_U_BIT   = 4;
    localparam int unsigned PTE_G_BIT   = 5;
    localparam int unsigned PTE_A_BIT   = 6;
    localparam int unsigned PTE_D_BIT   = 7;
    // ppn occupies pte[31:10], ppn0 is its low VPN_W bits
    localparam int unsigned PTE_PPN_LSB = 10;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_lvl_e;

    // only the page fault causes are produced here
    typedef enum logic [4:0] {
        EXC_NONE              = 5'd0,
        EXC_INSTR_PAGE_FAULT  = 5'd12,
        EXC_LOAD_PAGE_FAULT   = 5'd13,
        EXC_STORE_PAGE_FAULT  = 5'd15
    } exc_cause_e;

    // walker states, level 1 is the root table
    typedef enum logic [2:0] {
        IDLE,
        LVL1_REQ,
        LVL1_WAIT,
        LVL0_REQ,
        LVL0_WAIT
    } ptw_state_e;

endpackage
